// ==== design/fetch_pkg.sv ====
package fetch_pkg;

    // bus and counter width
    localparam int addr_w    = 16;
    localparam int word_w    = 16;   // instruction word
    localparam int opcode_w  = 4;    // top bits of the word
    localparam int operand_w = 12;   // low bits of the word, jump target

    // program RAM geometry
    localparam int ram_aw    = 8;
    localparam int ram_depth = 1 << ram_aw;   // addresses alias modulo depth

    // address or bus value
    typedef logic [addr_w-1:0] addr_t;

    // instruction word as stored in the RAM
    typedef logic [word_w-1:0] word_t;

    typedef logic [ram_aw-1:0]    ram_idx_t;   // RAM row index
    typedef logic [operand_w-1:0] operand_t;   // jump target before extension

    // only jmp is decoded, anything else just gets fetched
    typedef enum logic [opcode_w-1:0] {
        op_nop = 4'h0,
        op_jmp = 4'hf
    } opcode_e;

    // fetch microsteps
    typedef enum logic [1:0] {
        step_addr,     // pc onto the bus, address register loads
        step_data,     // instruction register loads, counter steps
        step_exec,     // instruction presented, jmp loads the counter
        step_settle    // jmp only, output stage catches up
    } step_e;

endpackage

// ==== design/program_counter.sv ====
`timescale 1ns/1ps

module program_counter (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             count,
    input  logic             load,
    input  fetch_pkg::addr_t bus,
    output fetch_pkg::addr_t pc
);
    import fetch_pkg::*;

    // The counter has two stages. The working register changes on the edge
    // that sees the strobe, and the output stage picks the new value up on
    // the edge after that. Consumers of pc therefore see a count or a load
    // two edges after the strobe cycle.

    addr_t work_q;   // primary stage
    addr_t work_d;
    addr_t out_q;    // secondary stage

    // next working value
    always_comb begin
        work_d = work_q;
        if (load) begin
            work_d = bus;   // load beats count
        end else if (count) begin
            work_d = work_q + addr_t'(1);   // wraps ffff -> 0
        end
    end

    // primary stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            work_q <= '0;
        end else begin
            work_q <= work_d;
        end
    end

    // secondary stage trails the primary by one edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q <= '0;
        end else begin
            out_q <= work_q;
        end
    end

    assign pc = out_q;

endmodule

// ==== design/memory_unit.sv ====
`timescale 1ns/1ps

module memory_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mar_load,
    input  fetch_pkg::addr_t bus,
    input  logic             prog_we,
    input  fetch_pkg::addr_t prog_addr,
    input  fetch_pkg::word_t prog_data,
    output fetch_pkg::addr_t mar,
    output fetch_pkg::word_t ram_data
);
    import fetch_pkg::*;

    // The address register doubles as the RAM's read address register.
    // The read row is taken from the value the register is about to hold,
    // so the read data register and the address register update on the
    // same edge and ram_data always matches the row at mar.

    addr_t    mar_q;
    addr_t    mar_d;
    ram_idx_t rd_idx;
    ram_idx_t wr_idx;
    word_t    rd_q;

    word_t ram_q [ram_depth];   // program store, contents survive reset

    assign mar_d  = mar_load ? bus : mar_q;
    assign rd_idx = mar_d[ram_aw-1:0];       // low bits only, upper bits alias
    assign wr_idx = prog_addr[ram_aw-1:0];

    // address register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mar_q <= '0;
        end else begin
            mar_q <= mar_d;
        end
    end

    // program load port
    always_ff @(posedge clk) begin
        if (prog_we) begin
            ram_q[wr_idx] <= prog_data;
        end
    end

    // synchronous read, old data on a same-row write
    always_ff @(posedge clk) begin
        rd_q <= ram_q[rd_idx];
    end

    assign mar      = mar_q;
    assign ram_data = rd_q;

endmodule

// ==== design/fetch_control.sv ====
`timescale 1ns/1ps

module fetch_control (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             run,
    input  logic             start_load,
    input  fetch_pkg::addr_t start_addr,
    input  fetch_pkg::addr_t pc,
    input  fetch_pkg::word_t ram_data,
    output fetch_pkg::addr_t bus,
    output logic             pc_count,
    output logic             pc_load,
    output logic             mar_load,
    output fetch_pkg::word_t instr,
    output logic             instr_valid
);
    import fetch_pkg::*;

    step_e    step_q;
    step_e    step_d;
    word_t    ir_q;          // instruction register
    opcode_e  opcode;
    operand_t operand;
    logic     is_jmp;
    logic     idle;          // held at the instruction boundary
    logic     sel_pc;        // bus driver selects, one hot or none
    logic     sel_operand;
    logic     sel_start;

    // decode straight off the instruction register
    assign opcode  = opcode_e'(ir_q[word_w-1 -: opcode_w]);
    assign operand = ir_q[operand_w-1:0];
    assign is_jmp  = (opcode == op_jmp);

    assign idle = (step_q == step_addr) && !run;

    // next microstep
    always_comb begin
        step_d = step_q;
        case (step_q)
            step_addr: begin
                if (run) begin
                    step_d = step_data;
                end
            end
            step_data: begin
                step_d = step_exec;
            end
            step_exec: begin
                // jmp needs one more edge for the output stage
                step_d = is_jmp ? step_settle : step_addr;
            end
            step_settle: begin
                step_d = step_addr;
            end
            default: begin
                step_d = step_addr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_q <= step_addr;
        end else begin
            step_q <= step_d;
        end
    end

    // capture the fetched word, ram_data is valid in step_data
    always_ff @(posedge clk) begin
        if (step_q == step_data) begin
            ir_q <= ram_data;
        end
    end

    // driver select
    assign sel_pc      = (step_q == step_addr) && run;
    assign sel_operand = (step_q == step_exec) && is_jmp;
    assign sel_start   = idle && start_load;

    // shared bus mux, parks at zero with no driver
    always_comb begin
        bus = '0;
        if (sel_pc) begin
            bus = pc;
        end else if (sel_operand) begin
            bus = addr_t'(operand);   // zero extend
        end else if (sel_start) begin
            bus = start_addr;
        end
    end

    // strobes, one cycle each
    assign mar_load    = sel_pc;
    assign pc_count    = (step_q == step_data);
    assign pc_load     = sel_operand || sel_start;
    assign instr_valid = (step_q == step_exec);
    assign instr       = ir_q;

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             run,
    input  logic             start_load,
    input  fetch_pkg::addr_t start_addr,
    input  logic             prog_we,
    input  fetch_pkg::addr_t prog_addr,
    input  fetch_pkg::word_t prog_data,
    output fetch_pkg::addr_t pc,
    output fetch_pkg::word_t instr,
    output fetch_pkg::addr_t instr_addr,
    output logic             instr_valid
);
    import fetch_pkg::*;

    addr_t bus;        // shared bus, driven by the controller mux
    word_t ram_data;
    logic  pc_count;
    logic  pc_load;
    logic  mar_load;

    program_counter i_pc (
        .clk   (clk),
        .rst_n (rst_n),
        .count (pc_count),
        .load  (pc_load),
        .bus   (bus),
        .pc    (pc)
    );

    // address register is what the outside sees as instr_addr
    memory_unit i_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .mar_load  (mar_load),
        .bus       (bus),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .mar       (instr_addr),
        .ram_data  (ram_data)
    );

    fetch_control i_ctl (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .start_load  (start_load),
        .start_addr  (start_addr),
        .pc          (pc),
        .ram_data    (ram_data),
        .bus         (bus),
        .pc_count    (pc_count),
        .pc_load     (pc_load),
        .mar_load    (mar_load),
        .instr       (instr),
        .instr_valid (instr_valid)
    );

endmodule

// ==== bench/fetch_unit_assertions.sv ====
`timescale 1ns/1ps

module fetch_unit_assertions (
    input logic clk,
    input logic rst_n,
    input logic run,
    input logic pc_count,
    input logic pc_load,
    input logic mar_load,
    input logic instr_valid
);

    logic run_seen;   // run has been high since reset

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_seen <= 1'b0;
        end else if (run) begin
            run_seen <= 1'b1;
        end
    end

    // one cycle pulse only
    valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |=> !instr_valid)
        else $error("instr_valid high on two cycles in a row");

    load_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(pc_load && mar_load))
        else $error("pc_load and mar_load in the same cycle");

    quiet_until_run: assert property (@(posedge clk) disable iff (!rst_n)
        (!run_seen && !run) |-> !(pc_count || pc_load || mar_load))
        else $error("strobe fired before run was seen high");

endmodule

bind fetch_control fetch_unit_assertions i_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .run         (run),
    .pc_count    (pc_count),
    .pc_load     (pc_load),
    .mar_load    (mar_load),
    .instr_valid (instr_valid)
);

// ==== bench/tb_fetch_unit.sv ====
`timescale 1ns/1ps

module tb_fetch_unit;
    import fetch_pkg::*;

    // instructions per test
    localparam int n_seq   = 40;
    localparam int n_start = 20;
    localparam int n_jmp   = 200;
    localparam int n_stall = 120;
    localparam int n_wrap  = 6;
    localparam int max_stall = 10;   // longest idle stretch after a pulse

    localparam int fetch_cycles = (n_seq + n_start + n_jmp + n_stall + n_wrap) * 4;
    localparam int stall_cycles = n_stall * max_stall;
    localparam int load_cycles  = 3 * (ram_depth + 1) + 40;   // programs, reset, start loads
    localparam int cycle_limit  = fetch_cycles + stall_cycles + load_cycles + 100;

    logic  clk;
    logic  rst_n;
    logic  run;
    logic  start_load;
    addr_t start_addr;
    logic  prog_we;
    addr_t prog_addr;
    word_t prog_data;
    addr_t pc;
    word_t instr;
    addr_t instr_addr;
    logic  instr_valid;

    logic [31:0] lfsr;
    word_t       model_mem [ram_depth];
    addr_t       model_pc;
    int          err_count;
    int          check_count;
    int          pulse_count;
    int          cycle_cnt;

    fetch_unit i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .start_load  (start_load),
        .start_addr  (start_addr),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .pc          (pc),
        .instr       (instr),
        .instr_addr  (instr_addr),
        .instr_valid (instr_valid)
    );

    always #50 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("the run timed out after %0d cycles", cycle_cnt);
            $display("Done: errors found");
            $finish;
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        check_count++;
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    // any opcode but jmp
    function automatic word_t plain_word();
        word_t w;
        w = word_t'(rand_bits(word_w));
        if (opcode_e'(w[word_w-1 -: opcode_w]) == op_jmp) begin
            w[word_w-1] = 1'b0;
        end
        return w;
    endfunction

    function automatic word_t jump_mix_word();
        word_t w;
        if (rand_bits(2) == 32'd0) begin
            w = {op_jmp, operand_t'(rand_bits(operand_w))};
        end else begin
            w = plain_word();
        end
        return w;
    endfunction

    // fill the whole RAM while idle
    task automatic load_program(input logic with_jumps);
        word_t w;
        for (int i = 0; i < ram_depth; i++) begin
            @(negedge clk);
            w = with_jumps ? jump_mix_word() : plain_word();
            prog_we   = 1'b1;
            prog_addr = addr_t'(i);
            prog_data = w;
            model_mem[i] = w;
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic start_at(input addr_t a);
        @(negedge clk);
        start_load = 1'b1;
        start_addr = a;
        @(negedge clk);
        start_load = 1'b0;
        start_addr = '0;
        check_addr("pc", pc, model_pc);   // output stage not caught up yet
        @(negedge clk);   // two cycles after the load cycle
        check_addr("pc", pc, a);
        model_pc = a;
    endtask

    // compare one valid pulse and step the model
    task automatic check_pulse();
        word_t exp_word;
        exp_word = model_mem[model_pc[ram_aw-1:0]];
        check_word("instr", instr, exp_word);
        check_addr("instr_addr", instr_addr, model_pc);
        if (opcode_e'(exp_word[word_w-1 -: opcode_w]) == op_jmp) begin
            model_pc = addr_t'(exp_word[operand_w-1:0]);   // zero extended
        end else begin
            model_pc = model_pc + addr_t'(1);
        end
        pulse_count++;
    endtask

    // run n instructions with optional idle stretches and finish idle
    task automatic fetch_run(input int n, input logic stalls);
        int seen;
        int low_cnt;
        int stall_left;
        seen       = 0;
        low_cnt    = 0;
        stall_left = 0;
        while (seen < n || low_cnt < 3) begin
            @(negedge clk);
            low_cnt = run ? 0 : low_cnt + 1;
            if (instr_valid) begin
                check_pulse();
                seen++;
                if (stalls && rand_bits(2) == 32'd0) begin
                    stall_left = 3 + int'(rand_bits(3));
                end
            end
            // idle long enough for the output stage to settle
            if (low_cnt >= 3) begin
                check_addr("pc", pc, model_pc);
            end
            if (seen >= n) begin
                run = 1'b0;
            end else if (stall_left > 0) begin
                run = 1'b0;
                stall_left--;
            end else begin
                run = 1'b1;
            end
        end
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, err_count - errs_before);
        end
    endtask

    initial begin
        int errs;
        clk        = 1'b0;
        rst_n      = 1'b0;
        run        = 1'b0;
        start_load = 1'b0;
        start_addr = '0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        lfsr        = 32'h9ebadfad;
        model_pc    = '0;
        err_count   = 0;
        check_count = 0;
        pulse_count = 0;
        cycle_cnt   = 0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        errs = err_count;
        repeat (6) begin
            @(negedge clk);
            if (instr_valid) begin
                $display("instr_valid went high after reset while run was low");
                err_count++;
            end
            check_addr("pc", pc, addr_t'(0));
            check_addr("instr_addr", instr_addr, addr_t'(0));
        end
        end_test(1, "reset state", errs);

        errs = err_count;
        load_program(1'b0);
        fetch_run(n_seq, 1'b0);
        end_test(2, "sequential fetch", errs);

        errs = err_count;
        start_at(addr_t'(rand_bits(addr_w)));
        fetch_run(n_start, 1'b0);
        end_test(3, "start load", errs);

        errs = err_count;
        load_program(1'b1);
        fetch_run(n_jmp, 1'b0);
        end_test(4, "jumps", errs);

        errs = err_count;
        fetch_run(n_stall, 1'b1);   // same program as test 4
        end_test(5, "run stalls", errs);

        errs = err_count;
        load_program(1'b0);
        start_at(16'hfffe);
        fetch_run(n_wrap, 1'b0);
        check_addr("pc", pc, addr_t'(n_wrap - 2));   // fffe + n_wrap wraps past zero
        end_test(6, "wrap-around", errs);

        $display("checks %0d, pulses %0d, errors %0d", check_count, pulse_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== src.f ====
design/fetch_pkg.sv
design/program_counter.sv
design/memory_unit.sv
design/fetch_control.sv
design/fetch_unit.sv
bench/fetch_unit_assertions.sv
bench/tb_fetch_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module tb_fetch_unit -Mdir "$build_dir" -o sim_fetch_unit
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/sim_fetch_unit" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: no errors" "$log"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $log"
    exit 1
fi
